// File: addSub9.sv
`timescale 1ns/1ps

module addSub9
(
	input  multPkg::aluOp_t                  op,
	input  logic [multPkg::OperandWidth-1:0] aIn,
	input  logic [multPkg::OperandWidth-1:0] s,
	output logic [multPkg::SumWidth-1:0]     sum
);

	import multPkg::*;

	logic [SumWidth-1:0] aExt;
	logic [SumWidth-1:0] sExt;
	logic [SumWidth-1:0] operand;
	logic                carryIn;

	// Sign extension into the X position
	assign aExt = {aIn[OperandWidth-1], aIn};
	assign sExt = {s[OperandWidth-1], s};

	// Second operand and carry per operation
	always_comb
	begin
		case (op)
			AluAdd:
			begin
				operand = sExt;
				carryIn = 1'b0;
			end
			AluSub:
			begin
				operand = ~sExt;   // Inverted, plus one through carry
				carryIn = 1'b1;
			end
			default:
			begin
				operand = '0;      // Sum is just the extended A
				carryIn = 1'b0;
			end
		endcase
	end

	assign sum = aExt + operand + {{(SumWidth-1){1'b0}}, carryIn};

endmodule

// File: list.f
multPkg.sv
multControl.sv
addSub9.sv
productRegs.sv
multiplierTop.sv
multControl_chk.sv
tbMultiplier.sv

// File: multControl.sv
`timescale 1ns/1ps

module multControl
(
	input  logic            Clk,
	input  logic            reset,
	input  logic            run,
	input  logic            clearLoad,
	input  logic            m,
	output multPkg::aluOp_t op,
	output logic            shift,
	output logic            loadB,
	output logic            done
);

	import multPkg::*;

	// ========================================
	// States
	// ========================================

	typedef enum logic [4:0]
	{
		Start,
		ClearLoad,
		Clear,
		Add1,
		Add2,
		Add3,
		Add4,
		Add5,
		Add6,
		Add7,
		Sub8,
		Shift1,
		Shift2,
		Shift3,
		Shift4,
		Shift5,
		Shift6,
		Shift7,
		Shift8,
		Halt
	} state_t;

	state_t state;
	state_t nextState;

	always_ff @(posedge Clk)
	begin
		if (reset)
			state <= Start;
		else
			state <= nextState;
	end

	// ========================================
	// Next state
	// ========================================

	// m is the multiplier bit B[0] will hold after this edge,
	// so each shift state already decides the next position
	always_comb
	begin
		nextState = state;
		case (state)
			Start:
			begin
				if (run)
					nextState = Clear;
				else if (clearLoad)
					nextState = ClearLoad;
			end
			ClearLoad:
				nextState = Start;   // Single cycle, back to idle
			Clear:
			begin
				if (m)
					nextState = Add1;
				else
					nextState = Shift1;
			end
			Add1:
				nextState = Shift1;
			Shift1:
			begin
				if (m)
					nextState = Add2;
				else
					nextState = Shift2;
			end
			Add2:
				nextState = Shift2;
			Shift2:
			begin
				if (m)
					nextState = Add3;
				else
					nextState = Shift3;
			end
			Add3:
				nextState = Shift3;
			Shift3:
			begin
				if (m)
					nextState = Add4;
				else
					nextState = Shift4;
			end
			Add4:
				nextState = Shift4;
			Shift4:
			begin
				if (m)
					nextState = Add5;
				else
					nextState = Shift5;
			end
			Add5:
				nextState = Shift5;
			Shift5:
			begin
				if (m)
					nextState = Add6;
				else
					nextState = Shift6;
			end
			Add6:
				nextState = Shift6;
			Shift6:
			begin
				if (m)
					nextState = Add7;
				else
					nextState = Shift7;
			end
			Add7:
				nextState = Shift7;
			Shift7:
			begin
				if (m)
					nextState = Sub8;   // Sign bit of B carries negative weight
				else
					nextState = Shift8;
			end
			Sub8:
				nextState = Shift8;
			Shift8:
				nextState = Halt;
			Halt:
			begin
				if (!run)
					nextState = Start;   // Rearm only on release
			end
			default:
				nextState = Start;
		endcase
	end

	// ========================================
	// Outputs from state only
	// ========================================

	always_comb
	begin
		op    = AluNone;
		shift = 1'b0;
		loadB = 1'b0;
		done  = 1'b0;
		case (state)
			ClearLoad:
			begin
				op    = AluClear;
				loadB = 1'b1;
			end
			Clear:
				op = AluClear;
			Add1, Add2, Add3, Add4, Add5, Add6, Add7:
				op = AluAdd;
			Sub8:
				op = AluSub;
			Shift1, Shift2, Shift3, Shift4, Shift5, Shift6, Shift7, Shift8:
				shift = 1'b1;
			Halt:
				done = 1'b1;
			default:
			begin
				op    = AluNone;
				shift = 1'b0;
			end
		endcase
	end

endmodule

// File: multControl_chk.sv
`timescale 1ns/1ps

module multControl_chk
(
	input logic            Clk,
	input logic            reset,
	input logic            run,
	input multPkg::aluOp_t op,
	input logic            shift,
	input logic            loadB,
	input logic            done
);

	import multPkg::*;

	// ========================================
	// Sequencer output rules
	// ========================================

	// One datapath action per cycle
	opShiftExclusive: assert property (@(posedge Clk) disable iff (reset)
		!(op != AluNone && shift))
		else $error("Arithmetic and shift active in the same cycle");

	loadWithClear: assert property (@(posedge Clk) disable iff (reset)
		loadB |-> op == AluClear)
		else $error("B load without clearing X and A");

	haltIsQuiet: assert property (@(posedge Clk) disable iff (reset)
		done |-> (op == AluNone && !shift))
		else $error("Datapath active while done");

	// Halt is left only on release of run
	haltHeld: assert property (@(posedge Clk) disable iff (reset)
		(done && run) |=> done)
		else $error("done dropped while run still high");

endmodule

bind multControl multControl_chk i_chk
(
	.Clk   (Clk),
	.reset (reset),
	.run   (run),
	.op    (op),
	.shift (shift),
	.loadB (loadB),
	.done  (done)
);

// File: multPkg.sv
package multPkg;

	// ========================================
	// Datapath widths
	// ========================================

	localparam int OperandWidth = 8;                  // S, A and B
	localparam int SumWidth     = OperandWidth + 1;   // X and A as one signed word

	// ========================================
	// Operation codes
	// ========================================

	// Sequencer decodes a bit position into one of these,
	// the adder and the X/A register both act on it
	typedef enum logic [1:0]
	{
		AluNone  = 2'b00,   // Hold X and A
		AluAdd   = 2'b01,   // A plus S
		AluSub   = 2'b10,   // A minus S, eighth position only
		AluClear = 2'b11    // Zero X and A
	} aluOp_t;

endpackage

// File: multiplierTop.sv
`timescale 1ns/1ps

module multiplierTop
(
	input  logic                             Clk,
	input  logic                             reset,
	input  logic                             run,
	input  logic                             clearLoad,
	input  logic [multPkg::OperandWidth-1:0] switches,
	output logic                             xOut,
	output logic [multPkg::OperandWidth-1:0] aOut,
	output logic [multPkg::OperandWidth-1:0] bOut,
	output logic                             done
);

	import multPkg::*;

	aluOp_t              op;
	logic                shift;
	logic                loadB;
	logic                m;
	logic [SumWidth-1:0] sum;

	// ========================================
	// Decode: sequencer
	// ========================================

	multControl i_control
	(
		.Clk       (Clk),
		.reset     (reset),
		.run       (run),
		.clearLoad (clearLoad),
		.m         (m),
		.op        (op),
		.shift     (shift),
		.loadB     (loadB),
		.done      (done)
	);

	// ========================================
	// Execute: add and subtract
	// ========================================

	addSub9 i_addSub
	(
		.op  (op),
		.aIn (aOut),       // A register feeds back
		.s   (switches),   // S held on the switches for the whole run
		.sum (sum)
	);

	// ========================================
	// Result: X, A and B
	// ========================================

	productRegs i_regs
	(
		.Clk      (Clk),
		.reset    (reset),
		.op       (op),
		.shift    (shift),
		.loadB    (loadB),
		.sum      (sum),
		.switches (switches),
		.x        (xOut),
		.a        (aOut),
		.b        (bOut),
		.m        (m)
	);

endmodule

// File: productRegs.sv
`timescale 1ns/1ps

module productRegs
(
	input  logic                             Clk,
	input  logic                             reset,
	input  multPkg::aluOp_t                  op,
	input  logic                             shift,
	input  logic                             loadB,
	input  logic [multPkg::SumWidth-1:0]     sum,
	input  logic [multPkg::OperandWidth-1:0] switches,
	output logic                             x,
	output logic [multPkg::OperandWidth-1:0] a,
	output logic [multPkg::OperandWidth-1:0] b,
	output logic                             m
);

	import multPkg::*;

	// ========================================
	// X and A, upper half of the product
	// ========================================

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			x <= 1'b0;
			a <= '0;
		end
		else
		begin
			case (op)
				AluClear:
				begin
					x <= 1'b0;
					a <= '0;
				end
				AluAdd, AluSub:
				begin
					x <= sum[SumWidth-1];        // Sign of the partial sum
					a <= sum[OperandWidth-1:0];
				end
				default:
				begin
					if (shift)
						a <= {x, a[OperandWidth-1:1]};   // X replicated, X itself kept
				end
			endcase
		end
	end

	// ========================================
	// B, multiplier and lower half of the product
	// ========================================

	always_ff @(posedge Clk)
	begin
		if (reset)
			b <= '0;
		else if (loadB)
			b <= switches;
		else if (shift)
			b <= {a[0], b[OperandWidth-1:1]};   // A bit 0 moves into B
	end

	// Bit in B[0] after this edge
	// During a shift that is B[1], so the sequencer looks one step ahead
	always_comb
	begin
		if (shift)
			m = b[1];
		else
			m = b[0];
	end

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and take the verdict from sim.log
verilator --binary --timing --assert -f list.f --top-module tbMultiplier -o simMultiplier \
	&& ./obj_dir/simMultiplier | tee sim.log \
	&& grep -q "STATUS: PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// File: tbMultiplier.sv
`timescale 1ns/1ps

module tbMultiplier;

	import multPkg::*;

	localparam int RandomPairs = 200;
	localparam int NumOps      = 2 * 5 + 2 * RandomPairs + 3;   // Loads and runs
	localparam int CycleLimit  = NumOps * 30 + 100;

	logic                    Clk;
	logic                    reset;
	logic                    run;
	logic                    clearLoad;
	logic [OperandWidth-1:0] switches;
	logic                    xOut;
	logic [OperandWidth-1:0] aOut;
	logic [OperandWidth-1:0] bOut;
	logic                    done;

	// Expected response for the compare process
	logic                    expX;
	logic [OperandWidth-1:0] expA;
	logic [OperandWidth-1:0] expB;
	logic                    expDone;
	int                      expCycles;
	int                      measCycles;
	string                   testName;
	event                    resultReady;

	logic [OperandWidth-1:0] modelB;        // B as the testbench expects it
	logic [16:0]             lastProduct;   // Most recent reference product with sign
	int                      testCount  = 0;
	int                      errorCount = 0;
	int                      cycleCount = 0;

	logic [OperandWidth-1:0] cornerS [5] = '{8'h80, 8'h7F, 8'h00, 8'hFF, 8'h01};
	logic [OperandWidth-1:0] cornerB [5] = '{8'h80, 8'h80, 8'hFF, 8'hFF, 8'h80};

	multiplierTop i_dut
	(
		.Clk       (Clk),
		.reset     (reset),
		.run       (run),
		.clearLoad (clearLoad),
		.switches  (switches),
		.xOut      (xOut),
		.aOut      (aOut),
		.bOut      (bOut),
		.done      (done)
	);

	always #50 Clk = ~Clk;

	// ========================================
	// Reference model
	// ========================================

	// Sign bit on top of the 16-bit two's-complement product
	function automatic logic [16:0] refProduct(input logic signed [7:0] s,
		input logic signed [7:0] b);
		logic [15:0] p;
		p = {{8{s[7]}}, s} * {{8{b[7]}}, b};
		return {p[15], p};
	endfunction

	function automatic int countOnes(input logic [7:0] value);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++)
			n += value[i];
		return n;
	endfunction

	// ========================================
	// Stimulus tasks
	// ========================================

	task automatic requestCheck(input string name, input logic x, input logic [7:0] a,
		input logic [7:0] b, input logic d, input int cycles, input int measured);
		testName   = name;
		expX       = x;
		expA       = a;
		expB       = b;
		expDone    = d;
		expCycles  = cycles;
		measCycles = measured;
		-> resultReady;
		@(negedge Clk);   // Compare reads the outputs before anything moves
	endtask

	task automatic loadOperand(input logic [7:0] value);
		switches  = value;
		clearLoad = 1'b1;
		@(negedge Clk);
		clearLoad = 1'b0;
		@(negedge Clk);
		modelB = value;
	endtask

	// Leaves run high so the sequencer waits in halt
	task automatic runMultiply(input logic [7:0] s, input string name);
		logic [16:0] expected;
		int          cycles;
		int          measured;
		expected = refProduct(s, modelB);
		cycles   = 10 + countOnes(modelB);
		measured = 0;
		switches = s;
		run      = 1'b1;
		while (!done)
		begin
			@(negedge Clk);
			measured++;
		end
		requestCheck(name, expected[16], expected[15:8], expected[7:0], 1'b1, cycles, measured);
		lastProduct = expected;
		modelB      = expected[7:0];   // Low byte stays in B for chaining
	endtask

	task automatic releaseRun();
		run = 1'b0;
		@(negedge Clk);
	endtask

	// ========================================
	// Compare process
	// ========================================

	always
	begin
		int failsHere;
		@(resultReady);
		failsHere = 0;
		assert (xOut == expX)
		else
		begin
			$display("CHECK FAILED: xOut got %h expected %h", xOut, expX);
			failsHere++;
		end
		assert (aOut == expA)
		else
		begin
			$display("CHECK FAILED: aOut got %h expected %h", aOut, expA);
			failsHere++;
		end
		assert (bOut == expB)
		else
		begin
			$display("CHECK FAILED: bOut got %h expected %h", bOut, expB);
			failsHere++;
		end
		assert (done == expDone)
		else
		begin
			$display("CHECK FAILED: done got %h expected %h", done, expDone);
			failsHere++;
		end
		if (expCycles >= 0)
		begin
			assert (measCycles == expCycles)
			else
			begin
				$display("CHECK FAILED: latency got %h expected %h", measCycles, expCycles);
				failsHere++;
			end
		end
		testCount++;
		errorCount += failsHere;
		$display("Test %0d %s: %s", testCount, testName, (failsHere == 0) ? "ok" : "failed");
	end

	// Hang guard
	always @(posedge Clk)
	begin
		cycleCount++;
		if (cycleCount > CycleLimit)
		begin
			$display("Run stopped after %0d cycles without finishing the tests", CycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ========================================
	// Test sequence
	// ========================================

	initial
	begin
		logic [7:0] value;
		void'($urandom(88));
		Clk       = 1'b0;
		reset     = 1'b1;
		run       = 1'b0;
		clearLoad = 1'b0;
		switches  = '0;
		modelB    = '0;
		repeat (4) @(negedge Clk);
		reset = 1'b0;

		for (int i = 0; i < 5; i++)
		begin
			loadOperand(cornerB[i]);
			runMultiply(cornerS[i], $sformatf("corner %h x %h", cornerS[i], cornerB[i]));
			releaseRun();
		end

		// Each load follows a product, so X and A hold data before the clear
		for (int i = 0; i < RandomPairs; i++)
		begin
			value = 8'($urandom);
			loadOperand(value);
			requestCheck($sformatf("clear-load %0d", i), 1'b0, 8'h00, value, 1'b0, -1, -1);
			runMultiply(8'($urandom), $sformatf("random pair %0d", i));
			releaseRun();
		end

		loadOperand(8'($urandom));
		runMultiply(8'($urandom), "run before hold");
		for (int i = 0; i < 5; i++)
			requestCheck($sformatf("hold cycle %0d", i + 1), lastProduct[16],
				lastProduct[15:8], lastProduct[7:0], 1'b1, -1, -1);
		releaseRun();
		runMultiply(8'($urandom), "chained run");
		releaseRun();

		$display("Tests run %0d, failed checks %0d", testCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
